// File: src/apb_periph_pkg.sv
// Bus widths, address map and register constants of the APB peripheral, imported with ::*
package apb_periph_pkg;

    localparam int ADDR_WIDTH = 32;                     // APB and transaction address
    localparam int DATA_WIDTH = 32;                     // APB and transaction data

    localparam int RAM_DEPTH  = 16;                     // Scratch words
    localparam int RAM_AW     = 4;                      // Scratch word index width

    // Byte bases of the two windows
    localparam logic [ADDR_WIDTH-1:0] REG_BASE = 32'h0000_0000; // 4 words, 0x0..0xC
    localparam logic [ADDR_WIDTH-1:0] RAM_BASE = 32'h0000_0100; // RAM_DEPTH words

    localparam int REG_WIN_LSB = 4;                     // Register window is 16 bytes
    localparam int RAM_WIN_LSB = RAM_AW + 2;            // Scratch window is 64 bytes

    // Register word indices, sized to the shared target index
    localparam logic [RAM_AW-1:0] REG_ID_OFS  = 4'd0;   // Read-only ID
    localparam logic [RAM_AW-1:0] REG_A_OFS   = 4'd1;   // Read/write A
    localparam logic [RAM_AW-1:0] REG_B_OFS   = 4'd2;   // Read/write B
    localparam logic [RAM_AW-1:0] REG_CNT_OFS = 4'd3;   // Read-only write counter

    localparam logic [DATA_WIDTH-1:0] PERIPH_ID = 32'h5A9B_0001; // Returned by ID

endpackage

// File: src/apb_slave.sv
`timescale 1ns/1ps
// APB front end FSM; holds one valid/ready transaction per transfer and stretches PREADY
module apb_slave
    import apb_periph_pkg::*;
(
    input  logic                  i_clk_apb,   // APB clock
    input  logic                  i_rstn_apb,  // Async reset, active low
    input  logic                  i_psel,      // Peripheral select
    input  logic                  i_penable,   // Access phase
    input  logic                  i_pwrite,    // 1 write, 0 read
    input  logic [ADDR_WIDTH-1:0] i_paddr,     // Byte address
    input  logic [DATA_WIDTH-1:0] i_pwdata,    // Write data
    output logic [DATA_WIDTH-1:0] o_prdata,    // Read data, zero unless completing a read
    output logic                  o_pready,    // Transfer done
    output logic                  o_pslverr,   // Unmapped access
    output logic                  o_valid,     // Transaction held
    input  logic                  i_ready,     // Target side can take it
    output logic [ADDR_WIDTH-1:0] o_addr,      // Transaction address
    output logic                  o_rd0_wr1,   // Direction
    output logic [DATA_WIDTH-1:0] o_wr_data,   // Transaction write data
    input  logic                  i_rd_valid,  // Read response present
    input  logic [DATA_WIDTH-1:0] i_rd_data,   // Read response data
    input  logic                  i_err        // Decode error from merge
);

    typedef enum logic [1:0] {
        IDLE  = 2'b00,                         // No transaction held
        READ  = 2'b01,                         // Waiting on read response
        WRITE = 2'b10                          // Waiting on access phase
    } state_t;

    state_t state;
    state_t next_state;
    logic   done_q;                            // Transfer finished last cycle

    // APB holds address and data for the whole transfer
    assign o_addr    = i_paddr;
    assign o_rd0_wr1 = i_pwrite;
    assign o_wr_data = i_pwdata;

    assign o_prdata  = (o_pready && state == READ) ? i_rd_data : '0; // Only on completing read
    assign o_pslverr = o_pready && (state != IDLE) && i_err;          // Error rides on PREADY

    always_ff @(posedge i_clk_apb or negedge i_rstn_apb) begin
        if (!i_rstn_apb) begin
            state  <= IDLE;
            done_q <= 1'b0;
        end else begin
            state  <= next_state;
            done_q <= o_pready && (state != IDLE); // Mark completion edge
        end
    end

    // A back-to-back setup right after completion is held one cycle with valid low,
    // so targets see each transaction start as a fresh valid edge
    always_comb begin
        o_valid    = 1'b0;
        o_pready   = 1'b1;                     // Ready while idle
        next_state = state;
        case (state)
            IDLE: begin
                if (i_psel && !done_q) begin
                    o_valid  = 1'b1;           // Launch in setup phase
                    o_pready = 1'b0;
                    if (i_ready) begin
                        next_state = i_pwrite ? WRITE : READ;
                    end
                end else if (i_psel) begin
                    o_pready = 1'b0;           // Valid gap cycle
                end
            end
            READ: begin
                o_valid  = 1'b1;               // Held until response
                o_pready = i_rd_valid && i_penable;
                if (i_rd_valid && i_penable) begin
                    next_state = IDLE;
                end
            end
            WRITE: begin
                o_valid  = 1'b1;               // Target writes on first valid cycle
                o_pready = i_penable;
                if (i_penable) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // Error only on the completing access phase of a selected transfer
    a_err_with_ready: assert property (@(posedge i_clk_apb) disable iff (!i_rstn_apb)
        o_pslverr |-> o_pready && i_psel && i_penable)
        else $error("pslverr outside a completing access phase");

    // Master keeps PADDR steady across the held transaction
    a_paddr_stable: assert property (@(posedge i_clk_apb) disable iff (!i_rstn_apb)
        (state == READ || state == WRITE) |-> i_paddr == $past(i_paddr))
        else $error("paddr changed during transfer");

endmodule

// File: src/ctrl_regs.sv
`timescale 1ns/1ps
// Control registers behind the merge block; ID, A, B and a write counter, one-cycle reads
module ctrl_regs
    import apb_periph_pkg::*;
(
    input  logic                  i_clk_apb,   // APB clock
    input  logic                  i_rstn_apb,  // Async reset, active low
    input  logic                  i_valid,     // Routed transaction valid
    input  logic [RAM_AW-1:0]     i_idx,       // Register word index
    input  logic                  i_rd0_wr1,   // Direction
    input  logic [DATA_WIDTH-1:0] i_wr_data,   // Write data
    output logic                  o_rd_valid,  // Read data ready
    output logic [DATA_WIDTH-1:0] o_rd_data    // Registered read data
);

    logic [DATA_WIDTH-1:0] reg_a;              // Read/write A
    logic [DATA_WIDTH-1:0] reg_b;              // Read/write B
    logic [DATA_WIDTH-1:0] reg_cnt;            // Writes to A and B, wraps
    logic [DATA_WIDTH-1:0] rd_mux;             // Selected read word
    logic                  acc_q;              // Valid seen last cycle
    logic                  wr_first;           // First cycle of a write

    assign wr_first = i_valid && !acc_q && i_rd0_wr1; // Once per transaction

    always_comb begin
        case (i_idx)
            REG_ID_OFS:  rd_mux = PERIPH_ID;
            REG_A_OFS:   rd_mux = reg_a;
            REG_B_OFS:   rd_mux = reg_b;
            REG_CNT_OFS: rd_mux = reg_cnt;
            default:     rd_mux = '0;          // Outside register set
        endcase
    end

    always_ff @(posedge i_clk_apb or negedge i_rstn_apb) begin
        if (!i_rstn_apb) begin
            acc_q      <= 1'b0;
            o_rd_valid <= 1'b0;
            reg_a      <= '0;
            reg_b      <= '0;
            reg_cnt    <= '0;
        end else begin
            acc_q      <= i_valid;
            o_rd_valid <= i_valid && !i_rd0_wr1; // Follows valid one cycle late
            if (wr_first) begin
                case (i_idx)
                    REG_A_OFS: begin
                        reg_a   <= i_wr_data;
                        reg_cnt <= reg_cnt + 1'b1;
                    end
                    REG_B_OFS: begin
                        reg_b   <= i_wr_data;
                        reg_cnt <= reg_cnt + 1'b1;
                    end
                    default: begin
                        reg_cnt <= reg_cnt;    // ID and CNT ignore writes
                    end
                endcase
            end
        end
    end

    always_ff @(posedge i_clk_apb) begin
        if (i_valid) begin
            o_rd_data <= rd_mux;               // Capture while selected
        end
    end

endmodule

// File: src/scratch_ram.sv
`timescale 1ns/1ps
// Scratch memory target; writes on the first valid cycle, reads through two register stages
module scratch_ram
    import apb_periph_pkg::*;
(
    input  logic                  i_clk_apb,   // APB clock
    input  logic                  i_rstn_apb,  // Async reset, active low
    input  logic                  i_valid,     // Routed transaction valid
    input  logic [RAM_AW-1:0]     i_idx,       // Word index
    input  logic                  i_rd0_wr1,   // Direction
    input  logic [DATA_WIDTH-1:0] i_wr_data,   // Write data
    output logic                  o_rd_valid,  // Two cycles after valid
    output logic [DATA_WIDTH-1:0] o_rd_data    // Second stage data
);

    logic [DATA_WIDTH-1:0] mem [RAM_DEPTH];    // Storage array
    logic [RAM_AW-1:0]     idx_q;              // Stage 1 index
    logic                  s1_v;               // Stage 1 read in flight
    logic                  acc_q;              // Valid seen last cycle
    logic                  wr_first;           // First cycle of a write

    assign wr_first = i_valid && !acc_q && i_rd0_wr1;

    always_ff @(posedge i_clk_apb) begin
        if (wr_first) begin
            mem[i_idx] <= i_wr_data;           // Single write per transaction
        end
        idx_q     <= i_idx;                    // Stage 1
        o_rd_data <= mem[idx_q];               // Stage 2
    end

    always_ff @(posedge i_clk_apb or negedge i_rstn_apb) begin
        if (!i_rstn_apb) begin
            acc_q      <= 1'b0;
            s1_v       <= 1'b0;
            o_rd_valid <= 1'b0;
        end else begin
            acc_q      <= i_valid;
            s1_v       <= i_valid && !i_rd0_wr1;
            o_rd_valid <= s1_v && i_valid;     // Cleared once valid drops
        end
    end

    // Index held while a read walks the two stages
    a_idx_held: assert property (@(posedge i_clk_apb) disable iff (!i_rstn_apb)
        s1_v && i_valid |-> i_idx == idx_q)
        else $error("index changed while a read was in flight");

endmodule

// File: src/resp_merge.sv
`timescale 1ns/1ps
// Address decoder between front end and targets; routes valid and folds responses back
module resp_merge
    import apb_periph_pkg::*;
(
    input  logic                  i_valid,        // Transaction valid
    input  logic [ADDR_WIDTH-1:0] i_addr,         // Byte address
    input  logic                  i_rd0_wr1,      // Direction
    input  logic [DATA_WIDTH-1:0] i_wr_data,      // Write data
    output logic                  o_ready,        // Targets never stall
    output logic                  o_rd_valid,     // Merged read valid
    output logic [DATA_WIDTH-1:0] o_rd_data,      // Merged read data
    output logic                  o_err,          // Unmapped address
    output logic                  o_reg_valid,    // Valid to ctrl_regs
    output logic                  o_ram_valid,    // Valid to scratch_ram
    output logic [RAM_AW-1:0]     o_idx,          // Word index to targets
    output logic                  o_tgt_rd0_wr1,  // Direction to targets
    output logic [DATA_WIDTH-1:0] o_tgt_wr_data,  // Write data to targets
    input  logic                  i_reg_rd_valid, // ctrl_regs response
    input  logic [DATA_WIDTH-1:0] i_reg_rd_data,
    input  logic                  i_ram_rd_valid, // scratch_ram response
    input  logic [DATA_WIDTH-1:0] i_ram_rd_data
);

    logic reg_hit;                                // Inside register window
    logic ram_hit;                                // Inside scratch window

    assign reg_hit = i_addr[ADDR_WIDTH-1:REG_WIN_LSB] == REG_BASE[ADDR_WIDTH-1:REG_WIN_LSB];
    assign ram_hit = i_addr[ADDR_WIDTH-1:RAM_WIN_LSB] == RAM_BASE[ADDR_WIDTH-1:RAM_WIN_LSB];

    assign o_ready       = 1'b1;
    assign o_reg_valid   = i_valid && reg_hit;    // Only the hit target sees valid
    assign o_ram_valid   = i_valid && ram_hit;
    assign o_err         = i_valid && !reg_hit && !ram_hit;
    assign o_tgt_rd0_wr1 = i_rd0_wr1;
    assign o_tgt_wr_data = i_wr_data;

    // Word index, register offsets zero-extended
    assign o_idx = ram_hit ? i_addr[RAM_WIN_LSB-1:2] : RAM_AW'(i_addr[REG_WIN_LSB-1:2]);

    always_comb begin
        if (reg_hit) begin
            o_rd_valid = i_reg_rd_valid;
            o_rd_data  = i_reg_rd_data;
        end else if (ram_hit) begin
            o_rd_valid = i_ram_rd_valid;
            o_rd_data  = i_ram_rd_data;
        end else begin
            o_rd_valid = o_err;                   // Error answers at once
            o_rd_data  = '0;
        end
    end

    // One transfer in flight, so only one target answers at a time
    always_comb begin
        a_one_target: assert (!(i_reg_rd_valid && i_ram_rd_valid))
            else $error("both targets answered");
    end

endmodule

// File: src/apb_periph_top.sv
`timescale 1ns/1ps
// Peripheral top; APB front end, response merge, control registers and scratch memory
module apb_periph_top
    import apb_periph_pkg::*;
(
    input  logic                  i_clk_apb,   // APB clock
    input  logic                  i_rstn_apb,  // Async reset, active low
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [ADDR_WIDTH-1:0] i_paddr,
    input  logic [DATA_WIDTH-1:0] i_pwdata,
    output logic [DATA_WIDTH-1:0] o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr
);

    logic                  valid;              // Front end to merge
    logic                  ready;
    logic [ADDR_WIDTH-1:0] addr;
    logic                  rd0_wr1;
    logic [DATA_WIDTH-1:0] wr_data;
    logic                  rd_valid;           // Merge to front end
    logic [DATA_WIDTH-1:0] rd_data;
    logic                  err;
    logic                  reg_valid;          // Merge to targets
    logic                  ram_valid;
    logic [RAM_AW-1:0]     idx;
    logic                  tgt_rd0_wr1;
    logic [DATA_WIDTH-1:0] tgt_wr_data;
    logic                  reg_rd_valid;       // Targets to merge
    logic [DATA_WIDTH-1:0] reg_rd_data;
    logic                  ram_rd_valid;
    logic [DATA_WIDTH-1:0] ram_rd_data;

    apb_slave slave0 (
        .i_clk_apb (i_clk_apb),  .i_rstn_apb(i_rstn_apb),
        .i_psel    (i_psel),     .i_penable (i_penable),
        .i_pwrite  (i_pwrite),   .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),   .o_prdata  (o_prdata),
        .o_pready  (o_pready),   .o_pslverr (o_pslverr),
        .o_valid   (valid),      .i_ready   (ready),
        .o_addr    (addr),       .o_rd0_wr1 (rd0_wr1),
        .o_wr_data (wr_data),    .i_rd_valid(rd_valid),
        .i_rd_data (rd_data),    .i_err     (err)
    );

    resp_merge merge0 (
        .i_valid       (valid),        .i_addr        (addr),
        .i_rd0_wr1     (rd0_wr1),      .i_wr_data     (wr_data),
        .o_ready       (ready),        .o_rd_valid    (rd_valid),
        .o_rd_data     (rd_data),      .o_err         (err),
        .o_reg_valid   (reg_valid),    .o_ram_valid   (ram_valid),
        .o_idx         (idx),          .o_tgt_rd0_wr1 (tgt_rd0_wr1),
        .o_tgt_wr_data (tgt_wr_data),  .i_reg_rd_valid(reg_rd_valid),
        .i_reg_rd_data (reg_rd_data),  .i_ram_rd_valid(ram_rd_valid),
        .i_ram_rd_data (ram_rd_data)
    );

    ctrl_regs regs0 (
        .i_clk_apb (i_clk_apb),    .i_rstn_apb(i_rstn_apb),
        .i_valid   (reg_valid),    .i_idx     (idx),
        .i_rd0_wr1 (tgt_rd0_wr1),  .i_wr_data (tgt_wr_data),
        .o_rd_valid(reg_rd_valid), .o_rd_data (reg_rd_data)
    );

    scratch_ram ram0 (
        .i_clk_apb (i_clk_apb),    .i_rstn_apb(i_rstn_apb),
        .i_valid   (ram_valid),    .i_idx     (idx),
        .i_rd0_wr1 (tgt_rd0_wr1),  .i_wr_data (tgt_wr_data),
        .o_rd_valid(ram_rd_valid), .o_rd_data (ram_rd_data)
    );

endmodule

// File: tests/tb_apb_periph.sv
`timescale 1ns/1ps
// Self-checking testbench for apb_periph_top; built from compile.f with tb_apb_periph as top
module tb_apb_periph
    import apb_periph_pkg::*;
();

    localparam int CLK_PERIOD   = 100;           // ns
    localparam int RESET_CYCLES = 8;
    localparam int REG_ROUNDS   = 3;             // Write/read rounds on A and B
    localparam int RAM_OPS      = 40;            // Random scratch accesses
    localparam int ERR_OPS      = 12;            // Unmapped accesses
    localparam int GAP_OPS      = 40;            // Mixed accesses with idle gaps
    localparam int NUM_XFERS    = 4 + REG_ROUNDS * 5 + 4 + RAM_DEPTH + RAM_OPS
                                + ERR_OPS + 3 + RAM_DEPTH + GAP_OPS;
    localparam int WATCHDOG_NS  = (NUM_XFERS * 6 + RESET_CYCLES) * CLK_PERIOD;

    localparam logic [ADDR_WIDTH-1:0] REG_SPAN = 32'd16;               // 4 register words
    localparam logic [ADDR_WIDTH-1:0] RAM_SPAN = 32'(RAM_DEPTH * 4);   // Scratch bytes

    typedef struct packed {
        logic                  wr;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] exp_data;
        logic [DATA_WIDTH-1:0] act_data;
        logic                  exp_err;
        logic                  act_err;
    } xfer_rec_t;

    logic                  clk_apb = 1'b0;
    logic                  rstn_apb;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [ADDR_WIDTH-1:0] paddr;
    logic [DATA_WIDTH-1:0] pwdata;
    logic [DATA_WIDTH-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    logic [DATA_WIDTH-1:0] m_reg_a;              // Model of A
    logic [DATA_WIDTH-1:0] m_reg_b;              // Model of B
    logic [DATA_WIDTH-1:0] m_cnt;                // Model of write counter
    logic [DATA_WIDTH-1:0] m_ram [RAM_DEPTH];    // Model of scratch words

    xfer_rec_t rec_q [$];                        // Completed transfers awaiting compare
    integer    seed;
    int        n_checks;
    int        n_errors;
    int        chk_base;                         // Counts at test start
    int        err_base;

    apb_periph_top dut0 (
        .i_clk_apb (clk_apb),  .i_rstn_apb(rstn_apb),
        .i_psel    (psel),     .i_penable (penable),
        .i_pwrite  (pwrite),   .i_paddr   (paddr),
        .i_pwdata  (pwdata),   .o_prdata  (prdata),
        .o_pready  (pready),   .o_pslverr (pslverr)
    );

    always #(CLK_PERIOD / 2) clk_apb = ~clk_apb;

    function automatic logic [DATA_WIDTH-1:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] word_addr(input logic [ADDR_WIDTH-1:0] base,
                                                        input logic [RAM_AW-1:0]     idx);
        return base + {{(ADDR_WIDTH - RAM_AW - 2){1'b0}}, idx, 2'b00};
    endfunction

    // Expected {pslverr, prdata} of a read from the current model state
    function automatic logic [DATA_WIDTH:0] model_read(input logic [ADDR_WIDTH-1:0] addr);
        logic [ADDR_WIDTH-1:0] ofs;
        ofs = addr - REG_BASE;
        if (ofs < REG_SPAN) begin
            case (ofs[RAM_AW+1:2])
                REG_ID_OFS:  return {1'b0, PERIPH_ID};
                REG_A_OFS:   return {1'b0, m_reg_a};
                REG_B_OFS:   return {1'b0, m_reg_b};
                REG_CNT_OFS: return {1'b0, m_cnt};
                default:     return {1'b0, 32'h0};
            endcase
        end
        ofs = addr - RAM_BASE;
        if (ofs < RAM_SPAN) begin
            return {1'b0, m_ram[ofs[RAM_AW+1:2]]};
        end
        return {1'b1, 32'h0};                    // Unmapped answers zero with error
    endfunction

    function automatic void model_write(input logic [ADDR_WIDTH-1:0] addr,
                                        input logic [DATA_WIDTH-1:0] data);
        logic [ADDR_WIDTH-1:0] ofs;
        ofs = addr - REG_BASE;
        if (ofs < REG_SPAN) begin
            if (ofs[RAM_AW+1:2] == REG_A_OFS) begin
                m_reg_a = data;
                m_cnt   = m_cnt + 32'd1;
            end else if (ofs[RAM_AW+1:2] == REG_B_OFS) begin
                m_reg_b = data;
                m_cnt   = m_cnt + 32'd1;
            end                                  // ID and CNT stay
        end else begin
            ofs = addr - RAM_BASE;
            if (ofs < RAM_SPAN) begin
                m_ram[ofs[RAM_AW+1:2]] = data;
            end
        end
    endfunction

    // One APB transfer; returns at the negedge where PREADY is seen in the access phase
    task automatic apb_transfer(input logic                  wr,
                                input logic [ADDR_WIDTH-1:0] addr,
                                input logic [DATA_WIDTH-1:0] wdata);
        xfer_rec_t             rec;
        logic [DATA_WIDTH:0]   exp;
        exp          = model_read(addr);
        rec.wr       = wr;
        rec.addr     = addr;
        rec.exp_err  = exp[DATA_WIDTH];
        rec.exp_data = wr ? '0 : exp[DATA_WIDTH-1:0]; // prdata stays zero on writes
        if (wr) begin
            model_write(addr, wdata);
        end
        @(posedge clk_apb);
        psel    <= 1'b1;                         // Setup phase
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk_apb);
        penable <= 1'b1;                         // Access phase
        @(negedge clk_apb);
        while (pready !== 1'b1) begin
            @(negedge clk_apb);
        end
        rec.act_data = prdata;
        rec.act_err  = pslverr;
        rec_q.push_back(rec);
    endtask

    task automatic idle_cycles(input int n);
        @(posedge clk_apb);
        psel    <= 1'b0;
        penable <= 1'b0;
        repeat (n - 1) @(posedge clk_apb);
    endtask

    task automatic begin_test();
        chk_base = n_checks;
        err_base = n_errors;
    endtask

    task automatic end_test(input string name);
        idle_cycles(2);                          // Let the compare process drain
        $display("test %-14s finished: %0d checks, %0d errors", name,
                 n_checks - chk_base, n_errors - err_base);
    endtask

    task automatic test_reset_values();
        begin_test();
        @(negedge clk_apb);
        n_checks++;
        assert (pready === 1'b1) else begin
            $display("[FAIL] t=%0t o_pready expected=1 actual=%b", $time, pready);
            n_errors++;
        end
        apb_transfer(1'b0, word_addr(REG_BASE, REG_ID_OFS), '0);
        apb_transfer(1'b0, word_addr(REG_BASE, REG_A_OFS), '0);
        apb_transfer(1'b0, word_addr(REG_BASE, REG_B_OFS), '0);
        apb_transfer(1'b0, word_addr(REG_BASE, REG_CNT_OFS), '0);
        end_test("reset_values");
    endtask

    task automatic test_reg_rw();
        begin_test();
        for (int i = 0; i < REG_ROUNDS; i++) begin
            apb_transfer(1'b1, word_addr(REG_BASE, REG_A_OFS), rand32());
            apb_transfer(1'b1, word_addr(REG_BASE, REG_B_OFS), rand32());
            apb_transfer(1'b0, word_addr(REG_BASE, REG_A_OFS), '0);
            apb_transfer(1'b0, word_addr(REG_BASE, REG_B_OFS), '0);
            apb_transfer(1'b0, word_addr(REG_BASE, REG_CNT_OFS), '0); // Counts A and B writes
        end
        apb_transfer(1'b1, word_addr(REG_BASE, REG_ID_OFS), rand32());  // Ignored
        apb_transfer(1'b1, word_addr(REG_BASE, REG_CNT_OFS), rand32()); // Ignored
        apb_transfer(1'b0, word_addr(REG_BASE, REG_ID_OFS), '0);
        apb_transfer(1'b0, word_addr(REG_BASE, REG_CNT_OFS), '0);
        end_test("reg_rw");
    endtask

    task automatic test_ram_random();
        logic [DATA_WIDTH-1:0] r;
        begin_test();
        for (int w = 0; w < RAM_DEPTH; w++) begin
            apb_transfer(1'b1, word_addr(RAM_BASE, w[RAM_AW-1:0]), rand32()); // Known contents
        end
        for (int i = 0; i < RAM_OPS; i++) begin
            r = rand32();
            apb_transfer(r[4], word_addr(RAM_BASE, r[RAM_AW-1:0]), rand32());
        end
        end_test("ram_random");
    endtask

    task automatic test_unmapped();
        logic [DATA_WIDTH-1:0] r;
        logic [ADDR_WIDTH-1:0] a;
        logic [DATA_WIDTH:0]   exp;
        begin_test();
        for (int i = 0; i < ERR_OPS; i++) begin
            r = rand32();
            a = {r[31:2], 2'b00};
            if (i == 0) a = REG_BASE + REG_SPAN;  // Just past registers
            if (i == 1) a = RAM_BASE - 32'd4;     // Just below scratch
            if (i == 2) a = RAM_BASE + RAM_SPAN;  // Just past scratch
            exp = model_read(a);
            if (!exp[DATA_WIDTH]) a[31] = 1'b1;   // Move out of both windows
            apb_transfer(r[0], a, rand32());
        end
        apb_transfer(1'b0, word_addr(REG_BASE, REG_A_OFS), '0); // State untouched
        apb_transfer(1'b0, word_addr(REG_BASE, REG_B_OFS), '0);
        apb_transfer(1'b0, word_addr(REG_BASE, REG_CNT_OFS), '0);
        for (int w = 0; w < RAM_DEPTH; w++) begin
            apb_transfer(1'b0, word_addr(RAM_BASE, w[RAM_AW-1:0]), '0);
        end
        end_test("unmapped");
    endtask

    task automatic test_idle_gaps();
        logic [DATA_WIDTH-1:0] r;
        logic [ADDR_WIDTH-1:0] a;
        int                    gap;
        begin_test();
        for (int i = 0; i < GAP_OPS; i++) begin
            r = rand32();
            if (r[5]) begin
                a = word_addr(REG_BASE, {2'b00, r[1:0]});
            end else begin
                a = word_addr(RAM_BASE, r[RAM_AW-1:0]);
            end
            apb_transfer(r[4], a, rand32());
            gap = rand32() % 32'd3;              // Zero means back to back
            if (gap > 0) idle_cycles(gap);
        end
        end_test("idle_gaps");
    endtask

    // Compare process, drains completed transfers every falling edge
    always @(negedge clk_apb) begin : compare_results
        xfer_rec_t rec;
        while (rec_q.size() > 0) begin
            rec = rec_q.pop_front();
            n_checks++;
            assert (rec.act_err === rec.exp_err) else begin
                $display("[FAIL] t=%0t o_pslverr addr=%h expected=%b actual=%b",
                         $time, rec.addr, rec.exp_err, rec.act_err);
                n_errors++;
            end
            n_checks++;
            assert (rec.act_data === rec.exp_data) else begin
                $display("[FAIL] t=%0t o_prdata addr=%h wr=%b expected=%h actual=%h",
                         $time, rec.addr, rec.wr, rec.exp_data, rec.act_data);
                n_errors++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a transfer never completed", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main
        seed     = 64234;
        n_checks = 0;
        n_errors = 0;
        rstn_apb = 1'b0;                         // Hold reset from time zero
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        m_reg_a  = '0;
        m_reg_b  = '0;
        m_cnt    = '0;
        repeat (RESET_CYCLES) @(posedge clk_apb);
        rstn_apb <= 1'b1;
        test_reset_values();
        test_reg_rw();
        test_ram_random();
        test_unmapped();
        test_idle_gaps();
        $display("summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
src/apb_periph_pkg.sv
src/apb_slave.sv
src/ctrl_regs.sv
src/scratch_ram.sv
src/resp_merge.sv
src/apb_periph_top.sv
tests/tb_apb_periph.sv

// File: Makefile
# Verilator flow for the APB peripheral

VERILATOR ?= verilator
TB_TOP    ?= tb_apb_periph
RTL_TOP   ?= apb_periph_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  := TESTBENCH PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	-./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
